/* design/video_config.svh */
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// palette and field widths
`define PALETTE_SIZE   16       // colors in the luma palette
`define COLOR_W        4        // palette index bits
`define LUMA_W         6        // luma dac width
`define CHROMA_W       6        // chroma dac width, also the signed offset width
`define PHASE_W        4        // carrier phase step bits
`define AMP_W          3        // chroma amplitude bits
`define CARRIER_STEPS  16       // sine samples per color cycle

// analog levels on the luma pins
`define SYNC_LUMA      0        // sync tip
`define BLANK_LUMA     12       // blanking / porch level

// chroma zero level, dac midscale
`define CHROMA_MID     32

// colorburst, 180 degrees from the reference phase
`define BURST_PHASE    8
`define BURST_AMP      4

`endif

/* design/video_pkg.sv */
`default_nettype none

`include "video_config.svh"

package video_pkg;

    typedef logic [`LUMA_W-1:0]           luma_t;       // luma level
    typedef logic [`PHASE_W-1:0]          phase_t;      // carrier phase step
    typedef logic [`AMP_W-1:0]            amp_t;        // chroma amplitude
    typedef logic [`COLOR_W-1:0]          color_idx_t;  // palette index
    typedef logic [`CHROMA_W-1:0]         chroma_t;     // unsigned chroma sample
    typedef logic signed [`CHROMA_W-1:0]  chroma_off_t; // chroma around midscale
    typedef logic signed [3:0]            sine_t;       // one carrier sample

    // pixel as it arrives from the raster logic
    typedef struct packed {
        color_idx_t color;
        logic       sync;
        logic       blank;
        logic       burst;
    } pixel_t;

    // stage 1 -> stage 2
    typedef struct packed {
        luma_t  luma;
        phase_t phase;
        amp_t   amp;
        logic   sync;
        logic   blank;
        logic   burst;
    } lookup_t;

    // stage 2 -> stage 3
    typedef struct packed {
        luma_t       luma;
        chroma_off_t chroma_off; // already scaled by amplitude
        logic        sync;
        logic        blank;
        logic        burst;
    } mod_t;

    // power-up luma per color, black sits on the blank level
    parameter luma_t default_luma [`PALETTE_SIZE] = '{
        6'd12, 6'd63, 6'd26, 6'd45, 6'd30, 6'd38, 6'd22, 6'd52,
        6'd30, 6'd22, 6'd38, 6'd26, 6'd34, 6'd52, 6'd34, 6'd45
    };

    // hue of each color in 22.5 degree steps
    parameter phase_t color_phase [`PALETTE_SIZE] = '{
        4'd0, 4'd0, 4'd4, 4'd12, 4'd2, 4'd10, 4'd0, 4'd8,
        4'd5, 4'd6, 4'd4, 4'd0,  4'd0, 4'd10, 4'd0, 4'd0
    };

    // saturation, zero for black, white and the three greys
    parameter amp_t color_amp [`PALETTE_SIZE] = '{
        3'd0, 3'd0, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd4,
        3'd5, 3'd5, 3'd5, 3'd0, 3'd0, 3'd4, 3'd5, 3'd0
    };

    // 7*sin(2*pi*k/16) rounded, sums to zero over a cycle
    parameter sine_t sine_table [`CARRIER_STEPS] = '{
        4'sd0,  4'sd3,  4'sd5,  4'sd6,  4'sd7,  4'sd6,  4'sd5,  4'sd3,
        4'sd0, -4'sd3, -4'sd5, -4'sd6, -4'sd7, -4'sd6, -4'sd5, -4'sd3
    };

endpackage

`default_nettype wire

/* design/color_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module color_lookup
(
    input  logic                  clk_col16x_ntsc, // 16x color carrier
    input  logic                  rst_n,           // sync, active low
    input  video_pkg::pixel_t     pixel,           // one pixel per clock
    input  logic                  ce,              // low = chip selected
    input  logic                  rw,              // low = write, high = read
    input  video_pkg::color_idx_t addr,            // palette entry
    input  video_pkg::luma_t      data_in,         // luma to store
    output video_pkg::luma_t      data_out,        // luma read back
    output logic                  data_oe,         // drive data bus
    output video_pkg::lookup_t    looked           // to the modulator
);
    import video_pkg::*;

    luma_t palette [`PALETTE_SIZE]; // runtime adjustable luma
    logic  bus_wr;
    logic  bus_rd;

    assign bus_wr = !ce && !rw; // cpu write cycle
    assign bus_rd = !ce && rw;  // cpu read cycle

    // palette comes up with the stock levels, bus writes land on the edge
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `PALETTE_SIZE; i++)
            begin
                palette[i] <= default_luma[i];
            end
        end
        else if (bus_wr)
        begin
            palette[addr] <= data_in; // seen by the pixel on the next edge
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            data_oe <= 1'b0;
        end
        else
        begin
            data_oe <= bus_rd; // bus driven only for the cycle after a read
        end
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (bus_rd)
        begin
            data_out <= palette[addr];
        end
    end

    // stage 1 register
    always_ff @(posedge clk_col16x_ntsc)
    begin
        looked.luma  <= palette[pixel.color];     // writable level
        looked.phase <= color_phase[pixel.color]; // fixed hue
        looked.amp   <= color_amp[pixel.color];   // fixed saturation
        if (!rst_n)
        begin
            looked.sync  <= 1'b0;
            looked.blank <= 1'b0;
            looked.burst <= 1'b0;
        end
        else
        begin
            looked.sync  <= pixel.sync;
            looked.blank <= pixel.blank;
            looked.burst <= pixel.burst;
        end
    end

    // the data bus may only be driven right after a selected read cycle,
    // so it can never turn on while the chip is deselected
    a_oe_follows_read: assert property (
        @(posedge clk_col16x_ntsc) disable iff (!rst_n)
        $rose(data_oe) |-> $past(!ce && rw)
    );

endmodule

`default_nettype wire

/* design/chroma_modulator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module chroma_modulator
(
    input  logic               clk_col16x_ntsc, // 16x color carrier
    input  logic               rst_n,           // active low sync reset
    input  video_pkg::lookup_t looked,          // from the palette stage
    output video_pkg::mod_t    modded           // to the output stage
);
    import video_pkg::*;

    phase_t            phase_cnt; // free running carrier phase
    phase_t            sel_phase; // color hue or burst
    amp_t              sel_amp;
    phase_t            sine_idx;
    sine_t             sine_val;
    logic signed [7:0] product;   // sine * amplitude within -56..49
    logic signed [7:0] scaled;
    chroma_off_t       offset;

    // 16 steps per carrier cycle at one per clock
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            phase_cnt <= '0;
        end
        else
        begin
            phase_cnt <= phase_cnt + phase_t'(1); // wraps at 16
        end
    end

    // burst overrides the color's hue and saturation
    assign sel_phase = looked.burst ? phase_t'(`BURST_PHASE) : looked.phase;
    assign sel_amp   = looked.burst ? amp_t'(`BURST_AMP) : looked.amp;

    assign sine_idx = phase_cnt + sel_phase; // hue is a phase shift of the carrier
    assign sine_val = sine_table[sine_idx];

    // amplitude widened with a zero sign bit so the multiply stays signed
    assign product = 8'(sine_val) * 8'($signed({1'b0, sel_amp}));
    assign scaled  = product >>> 2;  // divide by 4 with floor
    assign offset  = scaled[5:0];    // fits since |offset| <= 14

    // stage 2 register
    always_ff @(posedge clk_col16x_ntsc)
    begin
        modded.luma       <= looked.luma;
        modded.chroma_off <= offset;
        if (!rst_n)
        begin
            modded.sync  <= 1'b0;
            modded.blank <= 1'b0;
            modded.burst <= 1'b0;
        end
        else
        begin
            modded.sync  <= looked.sync;
            modded.blank <= looked.blank;
            modded.burst <= looked.burst;
        end
    end

    // registered offset keeps inside the dac swing around midscale
    a_offset_range: assert property (
        @(posedge clk_col16x_ntsc) disable iff (!rst_n)
        ($signed(modded.chroma_off) >= -14) && ($signed(modded.chroma_off) <= 14)
    );

endmodule

`default_nettype wire

/* design/video_output.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module video_output
(
    input  logic               clk_col16x_ntsc, // 16x color carrier
    input  logic               rst_n,           // sync, active low
    input  video_pkg::mod_t    modded,          // from the modulator
    output video_pkg::luma_t   luma,            // luma dac pins
    output video_pkg::chroma_t chroma,          // chroma dac pins
    output logic               luma_sink        // pulls luma down during sync
);
    import video_pkg::*;

    luma_t   luma_nxt;
    chroma_t chroma_nxt;
    chroma_t chroma_mod; // modulated sample, unsigned

    // offset is two's complement, so a 6 bit add around midscale is exact
    assign chroma_mod = chroma_t'(`CHROMA_MID) + chroma_t'(modded.chroma_off);

    // sync beats blank beats picture
    always_comb
    begin
        if (modded.sync)
        begin
            luma_nxt   = luma_t'(`SYNC_LUMA);
            chroma_nxt = chroma_t'(`CHROMA_MID);
        end
        else if (modded.blank)
        begin
            luma_nxt   = luma_t'(`BLANK_LUMA);
            chroma_nxt = modded.burst ? chroma_mod : chroma_t'(`CHROMA_MID); // burst on porch
        end
        else
        begin
            luma_nxt   = modded.luma;
            chroma_nxt = chroma_mod;
        end
    end

    // pin registers, idle as sync level with no carrier
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            luma      <= luma_t'(`SYNC_LUMA);
            chroma    <= chroma_t'(`CHROMA_MID);
            luma_sink <= 1'b0;
        end
        else
        begin
            luma      <= luma_nxt;
            chroma    <= chroma_nxt;
            luma_sink <= modded.sync;
        end
    end

    // raster logic never asks for burst inside a sync pulse
    a_no_burst_in_sync: assert property (
        @(posedge clk_col16x_ntsc) disable iff (!rst_n)
        !(modded.sync && modded.burst)
    );

endmodule

`default_nettype wire

/* design/video_encoder_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_encoder_top
(
    input  logic                  clk_col16x_ntsc, // from pll
    input  logic                  rst_n,           // sync, active low
    input  video_pkg::pixel_t     pixel,           // pixel stream
    input  logic                  ce,              // chip enable, low active
    input  logic                  rw,              // low = write
    input  video_pkg::color_idx_t addr,            // palette register
    input  video_pkg::luma_t      data_in,         // cpu data, low 6 bits
    output video_pkg::luma_t      data_out,        // register readback
    output logic                  data_oe,         // readback bus enable
    output video_pkg::luma_t      luma,            // luma out
    output video_pkg::chroma_t    chroma,          // chroma out
    output logic                  luma_sink        // luma current sink
);
    import video_pkg::*;

    lookup_t looked; // stage 1 -> 2
    mod_t    modded; // stage 2 -> 3

    // palette lookup and register port
    color_lookup u_lookup (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .pixel           (pixel),
        .ce              (ce),
        .rw              (rw),
        .addr            (addr),
        .data_in         (data_in),
        .data_out        (data_out),
        .data_oe         (data_oe),
        .looked          (looked)
    );

    // carrier and colorburst
    chroma_modulator u_mod (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .looked          (looked),
        .modded          (modded)
    );

    // sync/blank levels and pin registers
    video_output u_out (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .modded          (modded),
        .luma            (luma),
        .chroma          (chroma),
        .luma_sink       (luma_sink)
    );

endmodule

`default_nettype wire

/* test/video_encoder_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module video_encoder_tb;
    import video_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int DRAIN        = 5;   // pipeline depth plus one
    localparam int N_SYNC       = 16;
    localparam int N_RANDOM_PIX = 512;
    localparam int N_WRITES     = 8;   // each write is followed by 4 pixels of that color
    localparam int N_CHROMA_PIX = 720;
    localparam int N_BURST      = 64;  // four full carrier cycles
    localparam int RUN_CYCLES   = RESET_CYCLES + 2 * N_SYNC + N_RANDOM_PIX + 5 * N_WRITES
                                + 2 * `PALETTE_SIZE + N_CHROMA_PIX + N_BURST + 8 + 5 * DRAIN;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

    // one pixel followed through the three stages
    typedef struct packed {
        logic   valid;   // sampled with reset released
        pixel_t px;
        luma_t  luma;    // palette entry at lookup time
        phase_t carrier; // carrier phase when it was modulated
    } hist_t;

    logic       clk_col16x_ntsc = 1'b0;
    logic       rst_n;
    pixel_t     pixel;
    logic       ce;
    logic       rw;
    color_idx_t addr;
    luma_t      data_in;
    luma_t      data_out;
    logic       data_oe;
    luma_t      luma;
    chroma_t    chroma;
    logic       luma_sink;

    luma_t   pal_model [`PALETTE_SIZE]; // palette as the cpu should see it
    hist_t   h1 = '0;
    hist_t   h2 = '0;
    hist_t   h3 = '0;                   // pixel now on the pins
    phase_t  carrier = '0;
    logic    primed = 1'b0;             // at least one edge seen
    logic    in_reset_q = 1'b0;         // last edge was a reset edge
    logic    rd_q = 1'b0;               // last edge was a read cycle
    luma_t   rd_exp = '0;
    phase_t  sel_phase;
    amp_t    sel_amp;
    phase_t  sine_idx;
    int      exp_off;
    luma_t   exp_luma;
    chroma_t exp_chroma;
    int      burst_cnt = 0;
    int      burst_sum = 0;
    int      fail_count = 0;
    int      tests_run = 0;
    int      test_start_fails = 0;
    int      cycles = 0;

    video_encoder_top u_dut (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .pixel           (pixel),
        .ce              (ce),
        .rw              (rw),
        .addr            (addr),
        .data_in         (data_in),
        .data_out        (data_out),
        .data_oe         (data_oe),
        .luma            (luma),
        .chroma          (chroma),
        .luma_sink       (luma_sink)
    );

    always #20 clk_col16x_ntsc = ~clk_col16x_ntsc; // 40 ns period

    // reference pipeline with one register per dut stage
    always @(posedge clk_col16x_ntsc)
    begin
        primed     <= 1'b1;
        in_reset_q <= !rst_n;
        h1.valid   <= rst_n;
        h1.px      <= pixel;
        h1.luma    <= pal_model[pixel.color]; // writes on this edge are not seen yet
        h2         <= h1;
        h2.carrier <= carrier;                // phase before this edge's increment
        h3         <= h2;
        rd_q       <= rst_n && !ce && rw;
        rd_exp     <= pal_model[addr];
        if (!rst_n)
        begin
            carrier <= '0;
            for (int i = 0; i < `PALETTE_SIZE; i++)
            begin
                pal_model[i] <= default_luma[i];
            end
        end
        else
        begin
            carrier <= carrier + phase_t'(1); // wraps at 16
            if (!ce && !rw)
                pal_model[addr] <= data_in;
        end
    end

    // expected pins for the pixel in h3
    always_comb
    begin
        sel_phase = h3.px.burst ? phase_t'(`BURST_PHASE) : color_phase[h3.px.color];
        sel_amp   = h3.px.burst ? amp_t'(`BURST_AMP) : color_amp[h3.px.color];
        sine_idx  = h3.carrier + sel_phase;
        exp_off   = chroma_offset(int'(sine_table[sine_idx]), int'(sel_amp));
        if (h3.px.sync)
            exp_luma = luma_t'(`SYNC_LUMA);
        else if (h3.px.blank)
            exp_luma = luma_t'(`BLANK_LUMA);
        else
            exp_luma = h3.luma;
        if (h3.px.sync || (h3.px.blank && !h3.px.burst))
            exp_chroma = chroma_t'(`CHROMA_MID);  // no carrier
        else
            exp_chroma = chroma_t'(`CHROMA_MID + exp_off);
    end

    // sum of burst samples in windows of 16
    always @(posedge clk_col16x_ntsc)
    begin
        if (h3.valid && h3.px.burst)
        begin
            if (burst_cnt == 16)
            begin
                burst_cnt <= 1;
                burst_sum <= int'(chroma);
            end
            else
            begin
                burst_cnt <= burst_cnt + 1;
                burst_sum <= burst_sum + int'(chroma);
            end
        end
        else
        begin
            burst_cnt <= 0; // a broken run starts over
            burst_sum <= 0;
        end
    end

    always @(posedge clk_col16x_ntsc)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    a_reset_luma: assert property (@(posedge clk_col16x_ntsc)
        in_reset_q |-> luma == luma_t'(`SYNC_LUMA))
        else note_mismatch("luma", 32'(`SYNC_LUMA), 32'($sampled(luma)));
    a_reset_chroma: assert property (@(posedge clk_col16x_ntsc)
        in_reset_q |-> chroma == chroma_t'(`CHROMA_MID))
        else note_mismatch("chroma", 32'(`CHROMA_MID), 32'($sampled(chroma)));
    a_reset_sink: assert property (@(posedge clk_col16x_ntsc)
        in_reset_q |-> !luma_sink)
        else note_mismatch("luma_sink", 32'(0), 32'($sampled(luma_sink)));
    a_luma: assert property (@(posedge clk_col16x_ntsc)
        h3.valid |-> luma == exp_luma)
        else note_mismatch("luma", 32'($sampled(exp_luma)), 32'($sampled(luma)));
    a_chroma: assert property (@(posedge clk_col16x_ntsc)
        h3.valid |-> chroma == exp_chroma)
        else note_mismatch("chroma", 32'($sampled(exp_chroma)), 32'($sampled(chroma)));
    a_sink: assert property (@(posedge clk_col16x_ntsc)
        h3.valid |-> luma_sink == h3.px.sync)
        else note_mismatch("luma_sink", 32'($sampled(h3.px.sync)), 32'($sampled(luma_sink)));
    // greys carry no carrier at all
    a_grey: assert property (@(posedge clk_col16x_ntsc)
        (h3.valid && !h3.px.sync && !h3.px.burst && color_amp[h3.px.color] == '0)
        |-> chroma == chroma_t'(`CHROMA_MID))
        else note_mismatch("chroma", 32'(`CHROMA_MID), 32'($sampled(chroma)));
    a_burst_sum: assert property (@(posedge clk_col16x_ntsc)
        burst_cnt == 16 |-> burst_sum == 16 * `CHROMA_MID)
        else note_mismatch("burst chroma sum", 32'(16 * `CHROMA_MID), 32'($sampled(burst_sum)));
    a_oe: assert property (@(posedge clk_col16x_ntsc)
        primed |-> data_oe == rd_q)  // high exactly one cycle after a read
        else note_mismatch("data_oe", 32'($sampled(rd_q)), 32'($sampled(data_oe)));
    a_data_out: assert property (@(posedge clk_col16x_ntsc)
        rd_q |-> data_out == rd_exp)
        else note_mismatch("data_out", 32'($sampled(rd_exp)), 32'($sampled(data_out)));

    // floor(sine * amp / 4)
    function automatic int chroma_offset(input int sine, input int amp);
        int p;
        p = sine * amp;
        if (p >= 0)
            return p / 4;
        return -((3 - p) / 4); // round toward minus infinity
    endfunction

    function automatic pixel_t make_pixel(input color_idx_t c, input logic s,
                                          input logic b, input logic bu);
        return '{c, s, b, bu};
    endfunction

    function automatic color_idx_t random_color();
        return color_idx_t'($urandom_range(`PALETTE_SIZE - 1, 0));
    endfunction

    function automatic pixel_t random_pixel();
        return make_pixel(random_color(), 1'b0, 1'b0, 1'b0);
    endfunction

    task automatic note_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        fail_count++;
        $display("FAIL %s: expected %0h, got %0h", name, expected, actual);
    endtask

    // one clock of pixel and bus stimulus
    task automatic drive_cycle(input pixel_t p, input logic c, input logic r,
                               input color_idx_t a, input luma_t d);
        @(posedge clk_col16x_ntsc);
        pixel   <= p;
        ce      <= c;
        rw      <= r;
        addr    <= a;
        data_in <= d;
    endtask

    task automatic send_pixel(input pixel_t p);
        drive_cycle(p, 1'b1, 1'b1, '0, '0); // bus idle
    endtask

    // flush the pipe so every pixel reaches its check before the report
    task automatic finish_test(input string name);
        int errs;
        repeat (DRAIN) send_pixel(make_pixel('0, 1'b0, 1'b0, 1'b0));
        @(negedge clk_col16x_ntsc); // actions of the last edge are done
        errs = fail_count - test_start_fails;
        if (errs == 0)
            $display("test %-10s ok", name);
        else
            $display("test %-10s %0d failed checks", name, errs);
        test_start_fails = fail_count;
        tests_run++;
    endtask

    initial
    begin
        color_idx_t k;
        luma_t      vals [`PALETTE_SIZE];
        void'($urandom(32'h7a5104e1));
        rst_n   = 1'b0;
        pixel   = make_pixel(color_idx_t'(2), 1'b1, 1'b0, 1'b0); // colored sync pixel in reset
        ce      = 1'b1;
        rw      = 1'b1;
        addr    = '0;
        data_in = '0;
        repeat (RESET_CYCLES) @(posedge clk_col16x_ntsc);
        rst_n <= 1'b1;
        finish_test("reset");

        repeat (N_SYNC) send_pixel(make_pixel(random_color(), 1'b1, 1'b0, 1'b0));
        repeat (N_SYNC) send_pixel(make_pixel(random_color(), 1'b0, 1'b1, 1'b0));
        finish_test("sync_blank");

        repeat (N_RANDOM_PIX) send_pixel(random_pixel());
        for (int i = 0; i < N_WRITES; i++)
        begin
            k = random_color();
            // same-edge pixel still gets the old level
            drive_cycle(make_pixel(k, 1'b0, 1'b0, 1'b0), 1'b0, 1'b0, k, luma_t'($urandom));
            repeat (4) send_pixel(make_pixel(k, 1'b0, 1'b0, 1'b0));
        end
        finish_test("palette");

        for (int i = 0; i < `PALETTE_SIZE; i++)
        begin
            vals[i] = luma_t'($urandom);
            drive_cycle(random_pixel(), 1'b0, 1'b0, color_idx_t'(i), vals[i]);
        end
        for (int i = 0; i < `PALETTE_SIZE; i++)
            drive_cycle(random_pixel(), 1'b0, 1'b1, color_idx_t'(i), '0);
        finish_test("readback");

        repeat (N_CHROMA_PIX) send_pixel(random_pixel());
        repeat (N_BURST) send_pixel(make_pixel(random_color(), 1'b0, 1'b1, 1'b1));
        repeat (8) send_pixel(make_pixel(random_color(), 1'b0, 1'b1, 1'b0));
        finish_test("chroma");

        $display("%0d tests run, %0d failed checks", tests_run, fail_count);
        if (fail_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* video_encoder_top.f */
+incdir+design
design/video_pkg.sv
design/color_lookup.sv
design/chroma_modulator.sv
design/video_output.sv
design/video_encoder_top.sv
test/video_encoder_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= video_encoder_tb
FILELIST  ?= video_encoder_top.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
